// File: src.f
source/filt_pkg.sv
source/vid_win_if.sv
source/line_buf_chain.sv
source/delay_pipe.sv
source/win_5x5_gen.sv
source/conv_5x5.sv
source/filt_5x5_top.sv
tb/filt_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the filter testbench with verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module filt_tb -o filt_sim \
    && ./obj_dir/filt_sim | tee /dev/stderr | grep -q "Test completed successfully" \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation did not pass"; exit 1; }

// File: tb/filt_tb.sv
module filt_tb
    import filt_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD    = 100;
    localparam int DATA_W    = 12;
    localparam int LINE_SIZE = 64;
    localparam int PIX_MAX   = (1 << DATA_W) - 1;
    localparam int FRAME_X   = 16;
    localparam int FRAME_Y   = 10;
    localparam int BLANK_CYC = 6;
    localparam int RST_CYC   = 5;
    localparam int LAT       = WIN_LATENCY + CONV_LATENCY;
    localparam int HIST      = 16;
    localparam int N_FRAMES  = 10;
    localparam int OUT_PER_FRAME = (FRAME_X - 4) * (FRAME_Y - 4);

    // worst case with three idle cycles before every pixel
    localparam int FRAME_CYC = BLANK_CYC + FRAME_Y * (BLANK_CYC + 4 * FRAME_X);
    localparam int STIM_CYC  = N_FRAMES * FRAME_CYC + 2 * RST_CYC + 4 * BLANK_CYC;

    typedef struct packed {
        int val;
        int cyc;
        int x;
        int y;
    } exp_t;

    logic              clk = 1'b0;
    logic              arst_n_i;
    logic              bypass_i;
    logic [DATA_W-1:0] pix_i;
    logic              de_i;
    logic              hs_i;
    logic              vs_i;
    logic [DATA_W-1:0] pix_o;
    logic              de_o;
    logic              hs_o;
    logic              vs_o;

    int   seed = 21;
    int   cyc = 0;
    int   rel_cyc = 32'h3fff_ffff;
    int   out_cnt = 0;
    int   frame_mem [FRAME_Y][FRAME_X];
    logic hist_hs [HIST];
    logic hist_vs [HIST];
    exp_t exp_q [$];

    int val_err = 0;
    int lat_err = 0;
    int sync_err = 0;
    int strobe_err = 0;
    int frame_err = 0;

    filt_5x5_top #(
        .DATA_WIDTH    (DATA_W),
        .LINE_SIZE_MAX (LINE_SIZE)
    ) dut (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .bypass_i (bypass_i),
        .pix_i    (pix_i),
        .de_i     (de_i),
        .hs_i     (hs_i),
        .vs_i     (vs_i),
        .pix_o    (pix_o),
        .de_o     (de_o),
        .hs_o     (hs_o),
        .vs_o     (vs_o)
    );

    initial begin
        forever #(PERIOD / 2) clk = ~clk;
    end

    // cycle count and the sync levels seen by the DUT
    always @(posedge clk) begin
        hist_hs[cyc % HIST] = hs_i;
        hist_vs[cyc % HIST] = vs_i;
        cyc = cyc + 1;
    end

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------

    // (x, y) is the lower-right pixel of the window
    function automatic int ref_pixel(input int x, input int y, input bit byp);
        int acc;
        if (byp) begin
            return frame_mem[y-2][x-2];
        end
        acc = 0;
        for (int r = 0; r < 5; r++) begin
            for (int c = 0; c < 5; c++) begin
                acc = acc + frame_mem[y-4+r][x-4+c] * int'(KERNEL[r][c]);
            end
        end
        acc = (acc + (1 << (NORM_SHIFT - 1))) >> NORM_SHIFT;
        if (acc > PIX_MAX) begin
            acc = PIX_MAX;
        end
        return acc;
    endfunction

    // ------------------------------------------------------------
    // output comparison
    // ------------------------------------------------------------

    always @(negedge clk) begin : compare_out
        exp_t e;
        if (arst_n_i && cyc >= rel_cyc + LAT) begin
            assert (hs_o == hist_hs[(cyc - LAT) % HIST] && vs_o == hist_vs[(cyc - LAT) % HIST])
            else begin
                sync_err++;
                $display("** Error at %0t: hs_o vs_o are %b %b, expected %b %b", $time,
                         hs_o, vs_o, hist_hs[(cyc - LAT) % HIST], hist_vs[(cyc - LAT) % HIST]);
            end
        end
        if (arst_n_i && de_o) begin
            out_cnt++;
            assert (vs_o) else begin
                strobe_err++;
                $display("de_o was high while vs_o was low at %0t", $time);
            end
            assert (exp_q.size() > 0) else begin
                strobe_err++;
                $display("de_o came with no output expected at %0t", $time);
            end
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                assert (int'(pix_o) == e.val) else begin
                    val_err++;
                    $display("** Error at %0t: output (%0d,%0d) is %0d, expected %0d",
                             $time, e.x, e.y, pix_o, e.val);
                end
                assert (cyc == e.cyc) else begin
                    lat_err++;
                    $display("** Error at %0t: output (%0d,%0d) came in cycle %0d, expected %0d",
                             $time, e.x, e.y, cyc, e.cyc);
                end
            end
        end
    end

    // ------------------------------------------------------------
    // stimulus tasks
    // ------------------------------------------------------------

    task automatic apply_reset();
        arst_n_i = 1'b0;
        de_i     = 1'b0;
        // anything still in flight is dropped by the reset
        exp_q.delete();
        repeat (RST_CYC) @(negedge clk);
        assert (!de_o && !hs_o && !vs_o) else begin
            frame_err++;
            $display("outputs were not cleared by the reset at %0t", $time);
        end
        arst_n_i = 1'b1;
        rel_cyc  = cyc;
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < 2 * LAT) begin
            @(negedge clk);
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            frame_err += exp_q.size();
            $display("%0d expected outputs never came, at %0t", exp_q.size(), $time);
            exp_q.delete();
        end
    endtask

    // a negative fill gives random pixels and a negative rst_line sends no reset
    task automatic send_frame(input int fill, input int gap_max, input bit byp,
                              input int rst_line);
        int   gap;
        int   outs_start;
        bit   live;
        exp_t e;
        live       = 1'b1;
        outs_start = out_cnt;
        bypass_i   = byp;
        for (int y = 0; y < FRAME_Y; y++) begin
            vs_i = 1'b1;
            hs_i = 1'b1;
            de_i = 1'b0;
            repeat (BLANK_CYC) @(negedge clk);
            hs_i = 1'b0;
            for (int x = 0; x < FRAME_X; x++) begin
                gap  = int'($unsigned($random(seed)) % (gap_max + 1));
                de_i = 1'b0;
                repeat (gap) @(negedge clk);
                if (fill < 0) begin
                    frame_mem[y][x] = int'($unsigned($random(seed)) % (PIX_MAX + 1));
                end else begin
                    frame_mem[y][x] = fill;
                end
                pix_i = DATA_W'(frame_mem[y][x]);
                de_i  = 1'b1;
                if (live && x >= 4 && y >= 4) begin
                    e.val = ref_pixel(x, y, byp);
                    e.cyc = cyc + LAT;
                    e.x   = x - 4;
                    e.y   = y - 4;
                    exp_q.push_back(e);
                end
                @(negedge clk);
                if (y == rst_line && x == FRAME_X / 2) begin
                    apply_reset();
                    live = 1'b0;
                end
            end
        end
        // blanking between frames
        de_i = 1'b0;
        hs_i = 1'b1;
        vs_i = 1'b0;
        repeat (BLANK_CYC) @(negedge clk);
        drain_outputs();
        if (rst_line < 0) begin
            assert (out_cnt - outs_start == OUT_PER_FRAME) else begin
                frame_err++;
                $display("frame gave %0d outputs instead of %0d, at %0t",
                         out_cnt - outs_start, OUT_PER_FRAME, $time);
            end
        end
    endtask

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------

    initial begin : stimulus
        int total_err;
        arst_n_i = 1'b0;
        bypass_i = 1'b0;
        pix_i    = '0;
        de_i     = 1'b0;
        hs_i     = 1'b1;
        vs_i     = 1'b0;
        apply_reset();
        repeat (BLANK_CYC) @(negedge clk);

        // back-to-back pixels
        send_frame(-1, 0, 1'b0, -1);
        send_frame(-1, 0, 1'b0, -1);
        // zero to three idle cycles between pixels
        send_frame(-1, 3, 1'b0, -1);
        send_frame(-1, 3, 1'b0, -1);
        // centre pixel path
        send_frame(-1, 0, 1'b1, -1);
        send_frame(-1, 3, 1'b1, -1);
        // flat frames
        send_frame(1234, 0, 1'b0, -1);
        send_frame(PIX_MAX, 1, 1'b0, -1);
        // reset in line 6 and then a clean frame
        send_frame(-1, 0, 1'b0, 5);
        send_frame(-1, 0, 1'b0, -1);

        total_err = val_err + lat_err + sync_err + strobe_err + frame_err;
        $write("outputs %0d, value errors %0d, latency errors %0d, ",
               out_cnt, val_err, lat_err);
        $display("sync errors %0d, strobe errors %0d, frame errors %0d",
                 sync_err, strobe_err, frame_err);
        if (total_err == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // twice the longest possible stimulus
    initial begin : watchdog
        #(2 * STIM_CYC * PERIOD);
        $display("the run did not finish within %0d cycles, stopped by the watchdog",
                 2 * STIM_CYC);
        $display("Test failed");
        $finish;
    end

endmodule

// File: source/filt_5x5_top.sv
module filt_5x5_top
    import filt_pkg::*;
#(
    parameter int DATA_WIDTH = DATA_WIDTH_DEF,
    parameter int LINE_SIZE_MAX = LINE_SIZE_DEF
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  bypass_i,

    // raster input, X by Y
    input  logic [DATA_WIDTH-1:0] pix_i,
    input  logic                  de_i,
    input  logic                  hs_i,
    input  logic                  vs_i,

    // filtered output, (X-4) by (Y-4)
    output logic [DATA_WIDTH-1:0] pix_o,
    output logic                  de_o,
    output logic                  hs_o,
    output logic                  vs_o
);

    // ------------------------------------------------------------
    // window link between the two stages
    // ------------------------------------------------------------

    vid_win_if #(
        .DATA_WIDTH (DATA_WIDTH)
    ) win_if ();

    // ------------------------------------------------------------
    // stages
    // ------------------------------------------------------------

    win_5x5_gen #(
        .DATA_WIDTH    (DATA_WIDTH),
        .LINE_SIZE_MAX (LINE_SIZE_MAX)
    ) u_win_gen (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .pix_i    (pix_i),
        .de_i     (de_i),
        .hs_i     (hs_i),
        .vs_i     (vs_i),
        .win      (win_if.gen)
    );

    conv_5x5 #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_conv (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .bypass_i (bypass_i),
        .win      (win_if.conv),
        .pix_o    (pix_o),
        .de_o     (de_o),
        .hs_o     (hs_o),
        .vs_o     (vs_o)
    );

endmodule

// File: source/conv_5x5.sv
module conv_5x5
    import filt_pkg::*;
#(
    parameter int DATA_WIDTH = DATA_WIDTH_DEF
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  bypass_i,
    vid_win_if.conv               win,
    output logic [DATA_WIDTH-1:0] pix_o,
    output logic                  de_o,
    output logic                  hs_o,
    output logic                  vs_o
);

    localparam int PROD_W = DATA_WIDTH + KERNEL_W;
    // one spare bit keeps the rounding add from wrapping
    localparam int ACC_W = DATA_WIDTH + NORM_SHIFT + 1;
    localparam logic [ACC_W-1:0] ROUND_HALF = ACC_W'(1) << (NORM_SHIFT - 1);
    localparam logic [DATA_WIDTH-1:0] PIX_MAX = '1;

    logic [4:0][4:0][PROD_W-1:0] prod;
    logic [4:0][ACC_W-1:0]       row_sum_c;
    logic [4:0][ACC_W-1:0]       row_sum;
    logic [ACC_W-1:0]            total_c;
    logic [ACC_W-1:0]            total;
    logic [ACC_W-1:0]            rounded;
    logic [DATA_WIDTH:0]         scaled;
    logic [DATA_WIDTH-1:0]       centre_d;
    logic [CONV_LATENCY-2:0]     vld;
    vid_sync_t                   sync_d;

    // ------------------------------------------------------------
    // stage 1: weight every pixel
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        for (int r = 0; r < 5; r++) begin
            for (int c = 0; c < 5; c++) begin
                prod[r][c] <= PROD_W'(win.win[r][c]) * PROD_W'(KERNEL[r][c]);
            end
        end
    end

    // ------------------------------------------------------------
    // stage 2 and 3: adder tree
    // ------------------------------------------------------------

    always_comb begin
        for (int r = 0; r < 5; r++) begin
            row_sum_c[r] = '0;
            for (int c = 0; c < 5; c++) begin
                row_sum_c[r] = row_sum_c[r] + ACC_W'(prod[r][c]);
            end
        end
    end

    always_comb begin
        total_c = '0;
        for (int r = 0; r < 5; r++) begin
            total_c = total_c + row_sum[r];
        end
    end

    always_ff @(posedge clk) begin
        row_sum <= row_sum_c;
        total   <= total_c;
    end

    // ------------------------------------------------------------
    // stage 4: round, saturate, bypass
    // ------------------------------------------------------------

    assign rounded = total + ROUND_HALF;
    assign scaled  = rounded[ACC_W-1:NORM_SHIFT];

    always_ff @(posedge clk) begin
        if (bypass_i) begin
            pix_o <= centre_d;
        end else if (scaled[DATA_WIDTH]) begin
            pix_o <= PIX_MAX;
        end else begin
            pix_o <= scaled[DATA_WIDTH-1:0];
        end
    end

    // window strobe follows the arithmetic stage by stage
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vld  <= '0;
            de_o <= 1'b0;
        end else begin
            vld  <= {vld[CONV_LATENCY-3:0], win.win_valid};
            de_o <= vld[CONV_LATENCY-2];
        end
    end

    // ------------------------------------------------------------
    // side paths
    // ------------------------------------------------------------

    // the centre pixel runs one stage short because stage 4 registers it
    delay_pipe #(
        .T     (logic [DATA_WIDTH-1:0]),
        .DEPTH (CONV_LATENCY - 1)
    ) u_centre_pipe (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .d_i      (win.win[2][2]),
        .q_o      (centre_d)
    );

    delay_pipe #(
        .T     (vid_sync_t),
        .DEPTH (CONV_LATENCY)
    ) u_sync_pipe (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .d_i      (win.sync),
        .q_o      (sync_d)
    );

    assign hs_o = sync_d.hs;
    assign vs_o = sync_d.vs;

endmodule

// File: source/win_5x5_gen.sv
module win_5x5_gen
    import filt_pkg::*;
#(
    parameter int DATA_WIDTH = DATA_WIDTH_DEF,
    parameter int LINE_SIZE_MAX = LINE_SIZE_DEF
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic [DATA_WIDTH-1:0] pix_i,
    input  logic                  de_i,
    input  logic                  hs_i,
    input  logic                  vs_i,
    vid_win_if.gen                win
);

    logic [2:0]                      col_cnt;
    logic [2:0]                      col_cnt_nxt;
    logic [2:0]                      line_cnt;
    logic [2:0]                      line_cnt_nxt;
    logic                            hs_prev;
    logic                            frame_armed;
    logic                            line_start;
    logic                            win_ok;
    logic                            win_ok_d1;
    logic                            win_valid_q;
    logic                            de_d1;
    logic [DATA_WIDTH-1:0]           pix_d1;
    logic [3:0][DATA_WIDTH-1:0]      tap;
    logic [4:0][4:0][DATA_WIDTH-1:0] win_q;
    vid_sync_t                       sync_sr [WIN_LATENCY];

    // ------------------------------------------------------------
    // column and line counting
    // ------------------------------------------------------------

    // outside the frame hs_prev is held high so the first line
    // is seen even when hs is already low as vs rises
    assign line_start = vs_i & hs_prev & ~hs_i;

    always_comb begin
        col_cnt_nxt = col_cnt;
        if (hs_i) begin
            col_cnt_nxt = '0;
        end else if (de_i && col_cnt != 3'd5) begin
            col_cnt_nxt = col_cnt + 3'd1;
        end
    end

    // lines only count once a frame start has been seen
    always_comb begin
        line_cnt_nxt = line_cnt;
        if (!vs_i) begin
            line_cnt_nxt = '0;
        end else if (line_start && frame_armed && line_cnt != 3'd5) begin
            line_cnt_nxt = line_cnt + 3'd1;
        end
    end

    assign win_ok = de_i && (col_cnt_nxt == 3'd5) && (line_cnt_nxt == 3'd5);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            col_cnt     <= '0;
            line_cnt    <= '0;
            hs_prev     <= 1'b1;
            frame_armed <= 1'b0;
        end else begin
            col_cnt  <= col_cnt_nxt;
            line_cnt <= line_cnt_nxt;
            hs_prev  <= hs_i | ~vs_i;
            if (!vs_i) begin
                frame_armed <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // line memories
    // ------------------------------------------------------------

    line_buf_chain #(
        .DATA_WIDTH    (DATA_WIDTH),
        .LINE_SIZE_MAX (LINE_SIZE_MAX)
    ) u_line_buf (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .wr_en_i   (de_i),
        .ptr_clr_i (hs_i | ~vs_i),
        .pix_i     (pix_i),
        .tap_o     (tap)
    );

    // ------------------------------------------------------------
    // window shift registers
    // ------------------------------------------------------------

    // taps arrive one cycle after the write, so the new pixel is
    // held one cycle to shift in together with them
    always_ff @(posedge clk) begin
        pix_d1 <= pix_i;
        if (de_d1) begin
            for (int r = 0; r < 5; r++) begin
                for (int c = 0; c < 4; c++) begin
                    win_q[r][c] <= win_q[r][c+1];
                end
            end
            // row 0 takes the oldest line
            for (int r = 0; r < 4; r++) begin
                win_q[r][4] <= tap[3-r];
            end
            win_q[4][4] <= pix_d1;
        end
    end

    // ------------------------------------------------------------
    // valid and sync alignment
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            de_d1       <= 1'b0;
            win_ok_d1   <= 1'b0;
            win_valid_q <= 1'b0;
            for (int i = 0; i < WIN_LATENCY; i++) begin
                sync_sr[i] <= '0;
            end
        end else begin
            de_d1       <= de_i;
            win_ok_d1   <= win_ok;
            win_valid_q <= win_ok_d1;
            sync_sr[0]  <= '{hs: hs_i, vs: vs_i};
            for (int i = 1; i < WIN_LATENCY; i++) begin
                sync_sr[i] <= sync_sr[i-1];
            end
        end
    end

    assign win.win       = win_q;
    assign win.win_valid = win_valid_q;
    assign win.sync      = sync_sr[WIN_LATENCY-1];

endmodule

// File: source/delay_pipe.sv
module delay_pipe #(
    parameter type T = logic,
    parameter int DEPTH = 1
) (
    input  logic clk,
    input  logic arst_n_i,
    input  T     d_i,
    output T     q_o
);

    T stage [DEPTH];

    // plain shift register where stage 0 takes the input
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= d_i;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign q_o = stage[DEPTH-1];

endmodule

// File: source/line_buf_chain.sv
module line_buf_chain #(
    parameter int DATA_WIDTH = 12,
    parameter int LINE_SIZE_MAX = 1024
) (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       wr_en_i,
    input  logic                       ptr_clr_i,
    input  logic [DATA_WIDTH-1:0]      pix_i,
    output logic [3:0][DATA_WIDTH-1:0] tap_o
);

    localparam int PTR_W = (LINE_SIZE_MAX > 1) ? $clog2(LINE_SIZE_MAX) : 1;
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(LINE_SIZE_MAX - 1);

    logic [PTR_W-1:0]      wr_ptr;
    logic [DATA_WIDTH-1:0] rd_word [4];

    // ------------------------------------------------------------
    // shared write pointer
    // ------------------------------------------------------------

    // all four memories are addressed by the current column
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
        end else if (ptr_clr_i) begin
            wr_ptr <= '0;
        end else if (wr_en_i) begin
            if (wr_ptr == PTR_LAST) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // memory cascade
    // ------------------------------------------------------------

    // the old word at this column is read before the write and moves
    // one memory further down, so memory k always holds line n-1-k
    for (genvar k = 0; k < 4; k++) begin : g_line
        logic [DATA_WIDTH-1:0] mem [LINE_SIZE_MAX];
        logic [DATA_WIDTH-1:0] wr_word;
        logic [DATA_WIDTH-1:0] tap_q;

        assign rd_word[k] = mem[wr_ptr];

        if (k == 0) begin : g_head
            assign wr_word = pix_i;
        end else begin : g_next
            assign wr_word = rd_word[k-1];
        end

        always_ff @(posedge clk) begin
            if (wr_en_i) begin
                mem[wr_ptr] <= wr_word;
                tap_q       <= mem[wr_ptr];
            end
        end

        assign tap_o[k] = tap_q;
    end

endmodule

// File: source/vid_win_if.sv
interface vid_win_if
    import filt_pkg::*;
#(
    parameter int DATA_WIDTH = DATA_WIDTH_DEF
);

    // ------------------------------------------------------------
    // window from the generator to the convolution
    // ------------------------------------------------------------

    // indexed [row][column] with row 0 the oldest line
    // and win[4][4] the newest pixel
    logic [4:0][4:0][DATA_WIDTH-1:0] win;

    // one-cycle strobe for each complete window
    logic win_valid;

    // input sync delayed to line up with the window
    vid_sync_t sync;

    modport gen (
        output win,
        output win_valid,
        output sync
    );

    modport conv (
        input win,
        input win_valid,
        input sync
    );

endinterface

// File: source/filt_pkg.sv
package filt_pkg;

    // ------------------------------------------------------------
    // stream defaults
    // ------------------------------------------------------------

    // pixel width used when the top level is not overridden
    localparam int DATA_WIDTH_DEF = 12;

    // longest line the line memories can hold
    localparam int LINE_SIZE_DEF = 1024;

    // sync levels that travel alongside the pixels
    // hs is high during horizontal blanking and vs is high for the active frame
    typedef struct packed {
        logic hs;
        logic vs;
    } vid_sync_t;

    // ------------------------------------------------------------
    // gaussian kernel
    // ------------------------------------------------------------

    // outer product of 1 4 6 4 1 whose weights add up to 256
    localparam int unsigned KERNEL [5][5] = '{
        '{1,  4,  6,  4, 1},
        '{4, 16, 24, 16, 4},
        '{6, 24, 36, 24, 6},
        '{4, 16, 24, 16, 4},
        '{1,  4,  6,  4, 1}
    };

    // bits needed for the largest weight (36)
    localparam int KERNEL_W = 6;

    // divide by the kernel sum
    localparam int NORM_SHIFT = 8;

    // ------------------------------------------------------------
    // latencies in clock cycles
    // ------------------------------------------------------------

    // de_i of the lower-right pixel to win_valid
    localparam int WIN_LATENCY = 2;

    // win_valid to de_o
    localparam int CONV_LATENCY = 4;

endpackage
